// File: ad9434_pkg.sv
`default_nettype none

package ad9434_pkg;

  // ************************************************************************
  // device geometry

  localparam int num_lanes = 4;
  localparam int adc_width = 12;
  localparam int dma_width = 16;

  // consecutive words to gain or lose pattern lock
  localparam int pn_sync_count = 16;

  // ************************************************************************
  // register map, word addresses

  localparam logic [13:0] reg_version_addr   = 14'h000;
  localparam logic [13:0] reg_scratch_addr   = 14'h002;
  localparam logic [13:0] reg_chan_ctrl_addr = 14'h010;
  localparam logic [13:0] reg_status_addr    = 14'h011;

  localparam logic [31:0] core_version = 32'h0001_0061;

  // pattern select codes
  localparam logic [3:0] pnseq_pn9  = 4'd0;
  localparam logic [3:0] pnseq_pn23 = 4'd1;

  typedef struct packed {
    logic [11:0] rsvd_hi;
    logic [3:0]  pnseq_sel;
    logic [12:0] rsvd_lo;
    logic        dfmt_enable;
    logic        dfmt_type;
    logic        dfmt_se;
  } chan_ctrl_t;

  typedef struct packed {
    logic [27:0] rsvd;
    logic        pn_err;
    logic        pn_oos;
    logic        adc_or;
    logic        dma_ovf;
  } status_t;

  // one bus word, decoded by address
  typedef union packed {
    chan_ctrl_t  chan_ctrl;
    status_t     status;
    logic [31:0] word;
  } reg_word_u;

endpackage

`default_nettype wire

// File: ad9434_capture.sv
`default_nettype none

module ad9434_capture (
  input  wire         adc_clk,
  input  wire         adc_rst,
  input  wire  [47:0] adc_data,
  input  wire         adc_or,
  output logic [47:0] lane_data,
  output logic        lane_valid,
  output logic        cap_or
);

  // device word, four packed samples
  always_ff @(posedge adc_clk) begin
    lane_data <= adc_data;
  end

  // over-range is ignored while the datapath is held
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      cap_or <= 1'b0;
    end else begin
      cap_or <= adc_or;
    end
  end

  // all lanes leave reset on the same edge
  always_ff @(posedge adc_clk) begin
    lane_valid <= ~adc_rst;
  end

endmodule

`default_nettype wire

// File: ad9434_datafmt.sv
`default_nettype none

module ad9434_datafmt (
  input  wire                                adc_clk,
  input  wire                                adc_rst,
  input  wire  [ad9434_pkg::adc_width-1:0]   data,
  input  wire                                valid,
  input  wire                                dfmt_enable,
  input  wire                                dfmt_type,
  input  wire                                dfmt_se,
  output logic [ad9434_pkg::dma_width-1:0]   data_out,
  output logic                               valid_out
);

  logic fmt_msb;

  // offset binary flips the top bit into two's complement
  assign fmt_msb = dfmt_type ? ~data[11] : data[11];

  always_ff @(posedge adc_clk) begin
    if (!dfmt_enable) begin
      data_out <= {4'h0, data};
    end else if (dfmt_se) begin
      data_out <= {{4{fmt_msb}}, fmt_msb, data[10:0]};
    end else begin
      data_out <= {4'h0, fmt_msb, data[10:0]};
    end
  end

  // valid walks alongside the sample
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid;
    end
  end

endmodule

`default_nettype wire

// File: ad9434_pack.sv
`default_nettype none

module ad9434_pack (
  input  wire         adc_clk,
  input  wire         adc_rst,
  input  wire  [63:0] fmt_data,
  input  wire  [3:0]  fmt_valid,
  output logic [63:0] dma_data,
  output logic        dma_dvalid
);

  // lane n lands in bits 16n+15 to 16n
  always_ff @(posedge adc_clk) begin
    dma_data <= fmt_data;
  end

  // only a complete word is handed to the dma
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      dma_dvalid <= 1'b0;
    end else begin
      dma_dvalid <= &fmt_valid;
    end
  end

  // formatters share one reset and one valid, so they never split
  assert property (@(posedge adc_clk) disable iff (adc_rst)
    (fmt_valid == 4'h0) || (fmt_valid == 4'hf));

endmodule

`default_nettype wire

// File: ad9434_pnmon.sv
`default_nettype none

module ad9434_pnmon (
  input  wire         adc_clk,
  input  wire         adc_rst,
  input  wire  [47:0] lane_data,
  input  wire         lane_valid,
  input  wire  [3:0]  pnseq_sel,
  output logic        pn_err,
  output logic        pn_oos
);

  logic [47:0] pn_expect;
  logic        expect_valid;
  logic        pn_match;
  logic        match_valid;
  logic [$clog2(ad9434_pkg::pn_sync_count)-1:0] run_cnt;

  // ************************************************************************
  // next 48 stream bits from the last 23 received ones
  // bit 47 of a word is the oldest, bit 0 the newest
  // pn9 is b[n] = b[n-9] ^ b[n-5], pn23 is b[n] = b[n-23] ^ b[n-18]

  function automatic logic [47:0] pn_next(input logic [47:0] word, input logic pn23);
    logic [22:0] hist;
    logic [47:0] next_word;
    logic        bit_n;
    hist = word[22:0];
    for (int i = 47; i >= 0; i--) begin
      bit_n = pn23 ? (hist[22] ^ hist[17]) : (hist[8] ^ hist[4]);
      next_word[i] = bit_n;
      hist = {hist[21:0], bit_n};
    end
    return next_word;
  endfunction

  // ************************************************************************
  // stage 1, predict from this word and compare against the last prediction

  always_ff @(posedge adc_clk) begin
    case (pnseq_sel)
      ad9434_pkg::pnseq_pn9:  pn_expect <= pn_next(lane_data, 1'b0);
      ad9434_pkg::pnseq_pn23: pn_expect <= pn_next(lane_data, 1'b1);
      // unknown pattern, nothing can match
      default:                pn_expect <= '0;
    endcase
    // an all-zero word would predict itself
    pn_match <= (lane_data == pn_expect) && (lane_data != 48'd0);
  end

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      expect_valid <= 1'b0;
      match_valid <= 1'b0;
    end else begin
      expect_valid <= lane_valid;
      match_valid <= lane_valid & expect_valid;
    end
  end

  // ************************************************************************
  // stage 2, error pulse and lock tracking

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      pn_err <= 1'b0;
      pn_oos <= 1'b1;
      run_cnt <= '0;
    end else if (match_valid) begin
      pn_err <= ~pn_oos & ~pn_match;
      // matches while unlocked, or misses while locked, count toward a change
      if (pn_match == pn_oos) begin
        if (int'(run_cnt) == ad9434_pkg::pn_sync_count - 1) begin
          pn_oos <= ~pn_oos;
          run_cnt <= '0;
        end else begin
          run_cnt <= run_cnt + 1'b1;
        end
      end else begin
        run_cnt <= '0;
      end
    end else begin
      pn_err <= 1'b0;
      run_cnt <= '0;
    end
  end

  // a locked stream has to miss many times before lock drops
  assert property (@(posedge adc_clk) disable iff (adc_rst) $rose(pn_err) |-> !pn_oos);

endmodule

`default_nettype wire

// File: ad9434_regmap.sv
`default_nettype none

module ad9434_regmap (
  input  wire         up_clk,
  input  wire         up_rstn,
  input  wire         up_wreq,
  input  wire  [13:0] up_waddr,
  input  wire  [31:0] up_wdata,
  output logic        up_wack,
  input  wire         up_rreq,
  input  wire  [13:0] up_raddr,
  output logic [31:0] up_rdata,
  output logic        up_rack,
  input  wire         adc_clk,
  output logic        adc_rst,
  output logic        dfmt_enable,
  output logic        dfmt_type,
  output logic        dfmt_se,
  output logic [3:0]  pnseq_sel,
  input  wire         pn_err,
  input  wire         pn_oos,
  input  wire         cap_or,
  input  wire         dma_dovf
);

  ad9434_pkg::reg_word_u wr_word;
  ad9434_pkg::reg_word_u ctrl_word;
  ad9434_pkg::reg_word_u status_word;

  logic [31:0] up_scratch;
  logic        up_dfmt_enable;
  logic        up_dfmt_type;
  logic        up_dfmt_se;
  logic [3:0]  up_pnseq_sel;
  logic        up_pn_err;
  logic        up_adc_or;
  logic        up_dma_ovf;
  logic [3:0]  up_status_m1;
  logic [3:0]  up_status_m2;
  logic        wr_status;
  logic [1:0]  adc_rstn_m;
  logic [6:0]  adc_ctrl_m1;
  logic [6:0]  adc_ctrl_m2;

  assign wr_word = up_wdata;
  assign wr_status = up_wreq && (up_waddr == ad9434_pkg::reg_status_addr);

  // ************************************************************************
  // processor writes

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack <= 1'b0;
      up_scratch <= 32'd0;
      up_dfmt_enable <= 1'b0;
      up_dfmt_type <= 1'b0;
      up_dfmt_se <= 1'b0;
      up_pnseq_sel <= 4'd0;
    end else begin
      // unmapped writes are acknowledged too
      up_wack <= up_wreq;
      if (up_wreq && (up_waddr == ad9434_pkg::reg_scratch_addr)) begin
        up_scratch <= up_wdata;
      end
      if (up_wreq && (up_waddr == ad9434_pkg::reg_chan_ctrl_addr)) begin
        up_dfmt_enable <= wr_word.chan_ctrl.dfmt_enable;
        up_dfmt_type <= wr_word.chan_ctrl.dfmt_type;
        up_dfmt_se <= wr_word.chan_ctrl.dfmt_se;
        up_pnseq_sel <= wr_word.chan_ctrl.pnseq_sel;
      end
    end
  end

  // status into up_clk, then sticky; set wins over a same-cycle clear
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_status_m1 <= 4'd0;
      up_status_m2 <= 4'd0;
      up_pn_err <= 1'b0;
      up_adc_or <= 1'b0;
      up_dma_ovf <= 1'b0;
    end else begin
      up_status_m1 <= {pn_err, pn_oos, cap_or, dma_dovf};
      up_status_m2 <= up_status_m1;
      up_pn_err <= (up_pn_err & ~(wr_status & wr_word.status.pn_err)) | up_status_m2[3];
      up_adc_or <= (up_adc_or & ~(wr_status & wr_word.status.adc_or)) | up_status_m2[1];
      up_dma_ovf <= (up_dma_ovf & ~(wr_status & wr_word.status.dma_ovf)) | up_status_m2[0];
    end
  end

  // ************************************************************************
  // processor reads

  always_comb begin
    ctrl_word = '0;
    ctrl_word.chan_ctrl.dfmt_enable = up_dfmt_enable;
    ctrl_word.chan_ctrl.dfmt_type = up_dfmt_type;
    ctrl_word.chan_ctrl.dfmt_se = up_dfmt_se;
    ctrl_word.chan_ctrl.pnseq_sel = up_pnseq_sel;
    status_word = '0;
    status_word.status.pn_err = up_pn_err;
    // out-of-sync is live, not sticky
    status_word.status.pn_oos = up_status_m2[2];
    status_word.status.adc_or = up_adc_or;
    status_word.status.dma_ovf = up_dma_ovf;
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack <= 1'b0;
      up_rdata <= 32'd0;
    end else begin
      up_rack <= up_rreq;
      if (up_rreq) begin
        case (up_raddr)
          ad9434_pkg::reg_version_addr:   up_rdata <= ad9434_pkg::core_version;
          ad9434_pkg::reg_scratch_addr:   up_rdata <= up_scratch;
          ad9434_pkg::reg_chan_ctrl_addr: up_rdata <= ctrl_word.word;
          ad9434_pkg::reg_status_addr:    up_rdata <= status_word.word;
          default:                        up_rdata <= 32'd0;
        endcase
      end else begin
        up_rdata <= 32'd0;
      end
    end
  end

  // ************************************************************************
  // adc_clk side, datapath reset and control levels

  always_ff @(posedge adc_clk) begin
    adc_rstn_m <= {adc_rstn_m[0], up_rstn};
    adc_rst <= ~adc_rstn_m[1];
  end

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      adc_ctrl_m1 <= 7'd0;
      adc_ctrl_m2 <= 7'd0;
    end else begin
      adc_ctrl_m1 <= {up_dfmt_enable, up_dfmt_type, up_dfmt_se, up_pnseq_sel};
      adc_ctrl_m2 <= adc_ctrl_m1;
    end
  end

  assign {dfmt_enable, dfmt_type, dfmt_se, pnseq_sel} = adc_ctrl_m2;

  // requests last one cycle so each acknowledge is a single pulse
  assert property (@(posedge up_clk) disable iff (!up_rstn) up_wreq |=> !up_wreq);
  assert property (@(posedge up_clk) disable iff (!up_rstn) up_rreq |=> !up_rreq);

endmodule

`default_nettype wire

// File: ad9434_core.sv
`default_nettype none

module ad9434_core (
  // device interface
  input  wire         adc_clk,
  input  wire  [47:0] adc_data,
  input  wire         adc_or,

  // dma interface
  output wire         dma_dvalid,
  output wire  [63:0] dma_data,
  input  wire         dma_dovf,

  // processor interface
  input  wire         up_rstn,
  input  wire         up_clk,
  input  wire         up_wreq,
  input  wire  [13:0] up_waddr,
  input  wire  [31:0] up_wdata,
  output wire         up_wack,
  input  wire         up_rreq,
  input  wire  [13:0] up_raddr,
  output wire  [31:0] up_rdata,
  output wire         up_rack
);

  wire        adc_rst;
  wire [47:0] lane_data;
  wire        lane_valid;
  wire        cap_or;
  wire [63:0] fmt_data;
  wire [3:0]  fmt_valid;
  wire        dfmt_enable;
  wire        dfmt_type;
  wire        dfmt_se;
  wire [3:0]  pnseq_sel;
  wire        pn_err;
  wire        pn_oos;

  ad9434_capture capture_inst (
    .adc_clk    (adc_clk),
    .adc_rst    (adc_rst),
    .adc_data   (adc_data),
    .adc_or     (adc_or),
    .lane_data  (lane_data),
    .lane_valid (lane_valid),
    .cap_or     (cap_or)
  );

  // one formatter per sample lane
  genvar n;
  generate
    for (n = 0; n < ad9434_pkg::num_lanes; n++) begin : g_lane
      ad9434_datafmt datafmt_inst (
        .adc_clk     (adc_clk),
        .adc_rst     (adc_rst),
        .data        (lane_data[n*ad9434_pkg::adc_width +: ad9434_pkg::adc_width]),
        .valid       (lane_valid),
        .dfmt_enable (dfmt_enable),
        .dfmt_type   (dfmt_type),
        .dfmt_se     (dfmt_se),
        .data_out    (fmt_data[n*ad9434_pkg::dma_width +: ad9434_pkg::dma_width]),
        .valid_out   (fmt_valid[n])
      );
    end
  endgenerate

  ad9434_pack pack_inst (
    .adc_clk    (adc_clk),
    .adc_rst    (adc_rst),
    .fmt_data   (fmt_data),
    .fmt_valid  (fmt_valid),
    .dma_data   (dma_data),
    .dma_dvalid (dma_dvalid)
  );

  // pattern check runs on the raw lanes, ahead of formatting
  ad9434_pnmon pnmon_inst (
    .adc_clk    (adc_clk),
    .adc_rst    (adc_rst),
    .lane_data  (lane_data),
    .lane_valid (lane_valid),
    .pnseq_sel  (pnseq_sel),
    .pn_err     (pn_err),
    .pn_oos     (pn_oos)
  );

  ad9434_regmap regmap_inst (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .up_wreq     (up_wreq),
    .up_waddr    (up_waddr),
    .up_wdata    (up_wdata),
    .up_wack     (up_wack),
    .up_rreq     (up_rreq),
    .up_raddr    (up_raddr),
    .up_rdata    (up_rdata),
    .up_rack     (up_rack),
    .adc_clk     (adc_clk),
    .adc_rst     (adc_rst),
    .dfmt_enable (dfmt_enable),
    .dfmt_type   (dfmt_type),
    .dfmt_se     (dfmt_se),
    .pnseq_sel   (pnseq_sel),
    .pn_err      (pn_err),
    .pn_oos      (pn_oos),
    .cap_or      (cap_or),
    .dma_dovf    (dma_dovf)
  );

endmodule

`default_nettype wire

// File: tb_ad9434_core.sv
`default_nettype none

module tb_ad9434_core;

  localparam int ack_timeout = 20;
  localparam int poll_limit = 40;

  logic        clk;
  logic        up_rstn;
  logic [47:0] adc_data;
  logic        adc_or;
  logic        dma_dovf;
  logic        up_wreq;
  logic [13:0] up_waddr;
  logic [31:0] up_wdata;
  logic        up_rreq;
  logic [13:0] up_raddr;
  wire         dma_dvalid;
  wire  [63:0] dma_data;
  wire         up_wack;
  wire  [31:0] up_rdata;
  wire         up_rack;

  int          err_count;
  int          check_count;

  // stream control, set by the main sequence between clock edges
  logic        pn_mode;
  logic        pn_kind;
  int          corrupt_left;
  logic [22:0] pn_state;

  // model view of the formatter controls
  logic        cfg_enable;
  logic        cfg_type;
  logic        cfg_se;
  logic        chk_en;
  logic [63:0] expect_q[$];

  ad9434_core ad9434_core_inst (
    .adc_clk    (clk),
    .adc_data   (adc_data),
    .adc_or     (adc_or),
    .dma_dvalid (dma_dvalid),
    .dma_data   (dma_data),
    .dma_dovf   (dma_dovf),
    .up_rstn    (up_rstn),
    .up_clk     (clk),
    .up_wreq    (up_wreq),
    .up_waddr   (up_waddr),
    .up_wdata   (up_wdata),
    .up_wack    (up_wack),
    .up_rreq    (up_rreq),
    .up_raddr   (up_raddr),
    .up_rdata   (up_rdata),
    .up_rack    (up_rack)
  );

  // one source for both clock domains
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ************************************************************************
  // reporting

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    err_count++;
    $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic report_problem(input string msg);
    err_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // ************************************************************************
  // reference model

  // 12-bit raw sample to 16-bit dma sample
  function automatic logic [15:0] format_sample(input logic [11:0] s, input logic en,
                                                input logic typ, input logic se);
    logic msb;
    msb = typ ? ~s[11] : s[11];
    if (!en) begin
      return {4'h0, s};
    end
    return {(se ? {4{msb}} : 4'h0), msb, s[10:0]};
  endfunction

  function automatic logic [63:0] format_word(input logic [47:0] w);
    logic [63:0] r;
    for (int n = 0; n < 4; n++) begin
      r[16*n +: 16] = format_sample(w[12*n +: 12], cfg_enable, cfg_type, cfg_se);
    end
    return r;
  endfunction

  // x^9+x^5+1 or x^23+x^18+1, oldest bit of the word first
  task automatic next_pn_word(output logic [47:0] w);
    int tap_long;
    int tap_short;
    logic nb;
    tap_long = pn_kind ? 23 : 9;
    tap_short = pn_kind ? 18 : 5;
    for (int i = 47; i >= 0; i--) begin
      // pn_state[k] is the bit k+1 steps back
      nb = pn_state[tap_long-1] ^ pn_state[tap_short-1];
      w[i] = nb;
      pn_state = {pn_state[21:0], nb};
    end
  endtask

  // ************************************************************************
  // adc word driver and dma checker

  initial begin : adc_driver
    logic [47:0] w;
    adc_data = 48'd0;
    forever begin
      @(posedge clk);
      if (pn_mode) begin
        next_pn_word(w);
        if (corrupt_left > 0) begin
          // bit 47 is outside the history that predicts the next word
          w[47] = ~w[47];
          corrupt_left--;
        end
      end else begin
        w[47:32] = 16'($urandom);
        w[31:0] = $urandom;
      end
      adc_data <= w;
      expect_q.push_back(format_word(w));
    end
  end

  // three words in flight between adc_data and dma_data
  initial begin : dma_checker
    logic [63:0] exp_word;
    forever begin
      @(negedge clk);
      if (expect_q.size() > 3) begin
        exp_word = expect_q.pop_front();
        if (chk_en) begin
          check_count++;
          if (dma_data !== exp_word) report_mismatch("dma_data", dma_data, exp_word);
          if (dma_dvalid !== 1'b1) report_mismatch("dma_dvalid", 64'(dma_dvalid), 64'd1);
        end
      end
    end
  end

  // ************************************************************************
  // processor bus

  task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
    int n;
    logic seen;
    @(posedge clk);
    up_wreq <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    @(posedge clk);
    up_wreq <= 1'b0;
    n = 0;
    seen = 1'b0;
    while (!seen && n < ack_timeout) begin
      @(negedge clk);
      n++;
      seen = (up_wack === 1'b1);
    end
    if (!seen) report_problem("write acknowledge never arrived");
    else if (n != 1) report_problem("write acknowledge came late");
    @(negedge clk);
    if (up_wack !== 1'b0) report_problem("write acknowledge lasted more than one cycle");
  endtask

  task automatic read_reg(input logic [13:0] addr, output logic [31:0] data);
    int n;
    logic seen;
    @(posedge clk);
    up_rreq <= 1'b1;
    up_raddr <= addr;
    @(posedge clk);
    up_rreq <= 1'b0;
    n = 0;
    seen = 1'b0;
    data = 32'd0;
    while (!seen && n < ack_timeout) begin
      @(negedge clk);
      n++;
      if (up_rack === 1'b1) begin
        seen = 1'b1;
        data = up_rdata;
      end
    end
    if (!seen) report_problem("read acknowledge never arrived");
    else if (n != 1) report_problem("read acknowledge came late");
    @(negedge clk);
    if (up_rack !== 1'b0) report_problem("read acknowledge lasted more than one cycle");
    if (up_rdata !== 32'd0) report_mismatch("up_rdata", 64'(up_rdata), 64'd0);
  endtask

  task automatic expect_reg(input logic [13:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    read_reg(addr, rd);
    if (rd !== exp) report_mismatch(name, 64'(rd), 64'(exp));
  endtask

  // new formatter setting, dma checks paused until it has reached the lanes
  task automatic set_ctrl(input logic en, input logic typ, input logic se,
                          input logic [3:0] sel);
    logic [31:0] word;
    word = {12'd0, sel, 13'd0, en, typ, se};
    chk_en = 1'b0;
    write_reg(ad9434_pkg::reg_chan_ctrl_addr, word);
    cfg_enable = en;
    cfg_type = typ;
    cfg_se = se;
    expect_reg(ad9434_pkg::reg_chan_ctrl_addr, word, "up_rdata (chan_ctrl)");
    repeat (4) @(negedge clk);
    chk_en = 1'b1;
  endtask

  // poll the live out-of-sync bit
  task automatic wait_oos(input logic want, output logic [31:0] last);
    int tries;
    logic done;
    tries = 0;
    done = 1'b0;
    last = 32'd0;
    while (!done && tries < poll_limit) begin
      read_reg(ad9434_pkg::reg_status_addr, last);
      tries++;
      done = (last[2] === want);
    end
    if (!done) report_problem($sformatf("pn_oos in status never became %0d", want));
  endtask

  // ************************************************************************
  // main sequence

  initial begin : main_seq
    logic [31:0] rd;
    logic [31:0] scratch;
    int n;
    void'($urandom(32'h7437_9063));
    up_rstn = 1'b0;
    adc_or = 1'b0;
    dma_dovf = 1'b0;
    up_wreq = 1'b0;
    up_waddr = 14'd0;
    up_wdata = 32'd0;
    up_rreq = 1'b0;
    up_raddr = 14'd0;
    pn_mode = 1'b0;
    pn_kind = 1'b0;
    corrupt_left = 0;
    pn_state = 23'h7f_ffff;
    cfg_enable = 1'b0;
    cfg_type = 1'b0;
    cfg_se = 1'b0;
    chk_en = 1'b0;
    err_count = 0;
    check_count = 0;

    repeat (5) @(posedge clk);
    up_rstn <= 1'b1;
    n = 0;
    while (dma_dvalid !== 1'b1 && n < ack_timeout) begin
      @(negedge clk);
      n++;
    end
    if (dma_dvalid !== 1'b1) report_problem("dma_dvalid never rose after reset");
    repeat (3) @(negedge clk);
    chk_en = 1'b1;

    // registers after reset
    expect_reg(ad9434_pkg::reg_version_addr, ad9434_pkg::core_version, "up_rdata (version)");
    expect_reg(ad9434_pkg::reg_chan_ctrl_addr, 32'd0, "up_rdata (chan_ctrl)");
    expect_reg(ad9434_pkg::reg_status_addr, 32'h4, "up_rdata (status)");
    scratch = $urandom;
    write_reg(ad9434_pkg::reg_scratch_addr, scratch);
    expect_reg(ad9434_pkg::reg_scratch_addr, scratch, "up_rdata (scratch)");
    // addresses with bit 13 set are never mapped
    write_reg(14'h2000 | 14'($urandom), $urandom);
    expect_reg(14'h0001, 32'd0, "up_rdata (unmapped)");
    expect_reg(14'h3fff, 32'd0, "up_rdata (unmapped)");
    expect_reg(14'h2000 | 14'($urandom), 32'd0, "up_rdata (unmapped)");
    expect_reg(ad9434_pkg::reg_scratch_addr, scratch, "up_rdata (scratch)");

    // every formatter setting on random words
    for (int c = 0; c < 8; c++) begin
      set_ctrl(c[2], c[1], c[0], ad9434_pkg::pnseq_pn9);
      repeat (20) @(negedge clk);
    end

    // pn9 lock
    set_ctrl(1'b1, 1'b0, 1'b1, ad9434_pkg::pnseq_pn9);
    pn_state = 23'($urandom) | 23'h1;
    pn_kind = 1'b0;
    pn_mode = 1'b1;
    wait_oos(1'b0, rd);
    expect_reg(ad9434_pkg::reg_status_addr, 32'd0, "up_rdata (status)");

    // pn23 lock, the lost pn9 lock leaves an error to clear first
    set_ctrl(1'b1, 1'b1, 1'b0, ad9434_pkg::pnseq_pn23);
    wait_oos(1'b1, rd);
    write_reg(ad9434_pkg::reg_status_addr, 32'h8);
    pn_kind = 1'b1;
    wait_oos(1'b0, rd);
    expect_reg(ad9434_pkg::reg_status_addr, 32'd0, "up_rdata (status)");

    // single bad words keep lock but leave a sticky error
    for (int k = 0; k < 3; k++) begin
      corrupt_left = 1;
      repeat (8) @(negedge clk);
    end
    expect_reg(ad9434_pkg::reg_status_addr, 32'h8, "up_rdata (status)");
    write_reg(ad9434_pkg::reg_status_addr, 32'h8);
    expect_reg(ad9434_pkg::reg_status_addr, 32'd0, "up_rdata (status)");

    // a run of bad words drops lock
    corrupt_left = 16;
    n = 0;
    while (corrupt_left > 0 && n < poll_limit) begin
      @(negedge clk);
      n++;
    end
    if (corrupt_left > 0) report_problem("corrupted words were not all sent");
    wait_oos(1'b1, rd);
    if (rd !== 32'hc) report_mismatch("up_rdata (status)", 64'(rd), 64'hc);
    wait_oos(1'b0, rd);
    write_reg(ad9434_pkg::reg_status_addr, 32'h8);
    expect_reg(ad9434_pkg::reg_status_addr, 32'd0, "up_rdata (status)");

    // over-range and dma overflow are sticky until cleared
    @(posedge clk);
    adc_or <= 1'b1;
    @(posedge clk);
    adc_or <= 1'b0;
    repeat (6) @(negedge clk);
    expect_reg(ad9434_pkg::reg_status_addr, 32'h2, "up_rdata (status)");
    @(posedge clk);
    dma_dovf <= 1'b1;
    @(posedge clk);
    dma_dovf <= 1'b0;
    repeat (6) @(negedge clk);
    expect_reg(ad9434_pkg::reg_status_addr, 32'h3, "up_rdata (status)");
    repeat (10) @(negedge clk);
    expect_reg(ad9434_pkg::reg_status_addr, 32'h3, "up_rdata (status)");
    write_reg(ad9434_pkg::reg_status_addr, 32'h2);
    expect_reg(ad9434_pkg::reg_status_addr, 32'h1, "up_rdata (status)");
    write_reg(ad9434_pkg::reg_status_addr, 32'h1);
    expect_reg(ad9434_pkg::reg_status_addr, 32'd0, "up_rdata (status)");

    if (check_count == 0) report_problem("no dma word was ever compared");
    $display("dma checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
ad9434_pkg.sv
ad9434_capture.sv
ad9434_datafmt.sv
ad9434_pack.sv
ad9434_pnmon.sv
ad9434_regmap.sv
ad9434_core.sv
tb_ad9434_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_ad9434_core
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
